//--- design/z80_dp_pkg.sv
`default_nettype none

package z80_dp_pkg;

  // ------------------------------------------------
  // widths and plain vector types
  // ------------------------------------------------
  localparam int BYTE_W = 8;
  localparam int WORD_W = 16;

  // B, C, D, E, H, L, SPH, SPL, PCH, PCL live in one array of bytes
  localparam int NUM_REG8   = 10;
  // only B through L have a shadow copy
  localparam int NUM_SHADOW = 6;

  typedef logic [BYTE_W-1:0] byte_t;
  typedef logic [WORD_W-1:0] word_t;
  typedef logic [3:0]        reg8_sel_t;
  typedef logic [2:0]        pair_sel_t;
  typedef logic [2:0]        data_src_t;
  typedef logic [1:0]        addr_src_t;
  typedef logic [3:0]        alu_op_t;
  typedef logic [1:0]        flag_ovr_t;

  // byte register codes double as the index into the register array
  localparam reg8_sel_t R_B   = 4'd0;
  localparam reg8_sel_t R_C   = 4'd1;
  localparam reg8_sel_t R_D   = 4'd2;
  localparam reg8_sel_t R_E   = 4'd3;
  localparam reg8_sel_t R_H   = 4'd4;
  localparam reg8_sel_t R_L   = 4'd5;
  localparam reg8_sel_t R_SPH = 4'd6;
  localparam reg8_sel_t R_SPL = 4'd7;
  localparam reg8_sel_t R_PCH = 4'd8;
  localparam reg8_sel_t R_PCL = 4'd9;

  // a pair code times two gives the index of its high byte
  localparam pair_sel_t P_BC = 3'd0;
  localparam pair_sel_t P_DE = 3'd1;
  localparam pair_sel_t P_HL = 3'd2;
  localparam pair_sel_t P_SP = 3'd3;
  localparam pair_sel_t P_PC = 3'd4;

  // DS_EXT lets data_in onto the internal bus and keeps data_oe low
  localparam data_src_t DS_EXT  = 3'd0;
  localparam data_src_t DS_REG  = 3'd1;
  localparam data_src_t DS_A    = 3'd2;
  localparam data_src_t DS_F    = 3'd3;
  localparam data_src_t DS_TEMP = 3'd4;

  localparam addr_src_t AS_NONE = 2'd0;
  localparam addr_src_t AS_MAR  = 2'd1;
  localparam addr_src_t AS_PAIR = 2'd2;

  localparam alu_op_t OP_PASS = 4'd0;
  localparam alu_op_t OP_ADD  = 4'd1;
  localparam alu_op_t OP_ADC  = 4'd2;
  localparam alu_op_t OP_SUB  = 4'd3;
  localparam alu_op_t OP_AND  = 4'd4;
  localparam alu_op_t OP_INC  = 4'd5;
  localparam alu_op_t OP_CPL  = 4'd6;
  localparam alu_op_t OP_CCF  = 4'd7;

  // the upper bit marks an active override and the lower bit is the forced value
  localparam flag_ovr_t FO_KEEP = 2'b00;
  localparam flag_ovr_t FO_CLR  = 2'b10;
  localparam flag_ovr_t FO_SET  = 2'b11;

  // bit positions inside F
  localparam int FLAG_S  = 7;
  localparam int FLAG_Z  = 6;
  localparam int FLAG_H  = 4;
  localparam int FLAG_PV = 2;
  localparam int FLAG_N  = 1;
  localparam int FLAG_C  = 0;

  // ------------------------------------------------
  // control word from the sequencer
  // ------------------------------------------------
  typedef struct packed {
    flag_ovr_t s;
    flag_ovr_t z;
    flag_ovr_t h;
    flag_ovr_t pv;
    flag_ovr_t n;
    flag_ovr_t c;
  } flag_ctrl_t;

  typedef struct packed {
    data_src_t  data_src;
    addr_src_t  addr_src;
    reg8_sel_t  rf_rd_sel;
    pair_sel_t  rf_pair_sel;
    logic       rf_ld_en;
    reg8_sel_t  rf_ld_sel;
    logic       rf_pair_ld;
    logic       exx;
    logic       ex_de_hl;
    logic       ex_af;
    logic       ld_a;
    logic       a_from_alu;
    logic       ld_f;
    alu_op_t    alu_op;
    logic       alu_b_temp;
    flag_ctrl_t flag_ovr;
    logic       ld_temp;
    logic       ld_mar_hi;
    logic       ld_mar_lo;
    logic       mar_from_data;
  } dp_ctrl_t;

endpackage

`default_nettype wire

//--- design/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file
  import z80_dp_pkg::*;
(
  input  logic     clk,
  input  logic     arst_n,
  input  dp_ctrl_t ctrl,
  input  byte_t    dbus,
  input  word_t    abus,
  output byte_t    rd_byte,
  output word_t    rd_pair
);

  // ------------------------------------------------
  // storage
  // ------------------------------------------------
  // main set indexed directly by the byte register code
  byte_t regs_q [NUM_REG8];
  byte_t regs_d [NUM_REG8];
  // shadow set holds B' C' D' E' H' L' at the same indices as the main set
  byte_t shd_q  [NUM_SHADOW];
  byte_t shd_d  [NUM_SHADOW];

  // codes above PCL or above PC select nothing
  logic      rd_ok;
  logic      ld_ok;
  logic      pair_ok;
  reg8_sel_t pair_hi;
  reg8_sel_t pair_lo;

  // high byte of a pair sits at twice the pair code and the low byte right after it
  function automatic reg8_sel_t hi_index(input pair_sel_t p);
    return reg8_sel_t'({p, 1'b0});
  endfunction

  function automatic reg8_sel_t lo_index(input pair_sel_t p);
    return reg8_sel_t'({p, 1'b1});
  endfunction

  assign rd_ok   = (ctrl.rf_rd_sel <= R_PCL);
  assign ld_ok   = (ctrl.rf_ld_sel <= R_PCL);
  assign pair_ok = (ctrl.rf_pair_sel <= P_PC);
  assign pair_hi = hi_index(ctrl.rf_pair_sel);
  assign pair_lo = lo_index(ctrl.rf_pair_sel);

  // ------------------------------------------------
  // read ports
  // ------------------------------------------------
  // both ports are purely combinational so a value written at an edge
  // shows up on the buses in the very next cycle
  always_comb begin
    if (rd_ok) begin
      rd_byte = regs_q[ctrl.rf_rd_sel];
    end else begin
      rd_byte = '0;
    end
  end

  // the same pair select drives the read port and names the pair load target
  always_comb begin
    if (pair_ok) begin
      rd_pair = {regs_q[pair_hi], regs_q[pair_lo]};
    end else begin
      rd_pair = '0;
    end
  end

  // ------------------------------------------------
  // next state
  // ------------------------------------------------
  // each step below overwrites what the one before it wrote, so the last
  // step has the highest priority and EXX ends up winning over everything
  always_comb begin
    regs_d = regs_q;
    shd_d  = shd_q;

    // byte load from the data bus is the weakest write
    if (ctrl.rf_ld_en && ld_ok) begin
      regs_d[ctrl.rf_ld_sel] = dbus;
    end

    // a pair load takes both halves from the address bus
    if (ctrl.rf_pair_ld && pair_ok) begin
      regs_d[pair_hi] = abus[WORD_W-1:BYTE_W];
      regs_d[pair_lo] = abus[BYTE_W-1:0];
    end

    // EX DE,HL only touches the main set
    if (ctrl.ex_de_hl) begin
      regs_d[R_D] = regs_q[R_H];
      regs_d[R_E] = regs_q[R_L];
      regs_d[R_H] = regs_q[R_D];
      regs_d[R_L] = regs_q[R_E];
    end

    // EXX trades BC, DE and HL with the shadow set
    // SP and PC are left alone so a pair load to them still lands
    if (ctrl.exx) begin
      for (int i = 0; i < NUM_SHADOW; i++) begin
        regs_d[i] = shd_q[i];
        shd_d[i]  = regs_q[i];
      end
    end
  end

  // ------------------------------------------------
  // registers
  // ------------------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < NUM_REG8; i++) begin
        regs_q[i] <= '0;
      end
      for (int j = 0; j < NUM_SHADOW; j++) begin
        shd_q[j] <= '0;
      end
    end else begin
      regs_q <= regs_d;
      shd_q  <= shd_d;
    end
  end

endmodule

`default_nettype wire

//--- design/alu8.sv
`timescale 1ns/1ps
`default_nettype none

module alu8
  import z80_dp_pkg::*;
(
  input  alu_op_t op,
  input  byte_t   a,
  input  byte_t   b,
  input  byte_t   f_in,
  output byte_t   result,
  output byte_t   f_out
);

  // ------------------------------------------------
  // shared adder
  // ------------------------------------------------
  // ADD, ADC, SUB and INC all go through one adder
  // SUB adds the inverted operand with a carry in of one
  logic          is_sub;
  byte_t         addend;
  logic          cin;
  logic [4:0]    sum_lo;
  logic [8:0]    sum_full;
  byte_t         sum;
  logic          ovf;

  assign is_sub = (op == OP_SUB);

  always_comb begin
    case (op)
      OP_SUB:  addend = ~b;
      OP_INC:  addend = 8'h01;
      default: addend = b;
    endcase
  end

  assign cin = is_sub | ((op == OP_ADC) & f_in[FLAG_C]);

  // the low nibble sum is only needed for its carry into bit 4
  assign sum_lo   = {1'b0, a[3:0]} + {1'b0, addend[3:0]} + {4'b0, cin};
  assign sum_full = {1'b0, a} + {1'b0, addend} + {8'b0, cin};
  assign sum      = sum_full[BYTE_W-1:0];

  // overflow when both inputs agree in sign and the sum does not
  // with addend fixed at 01 this reduces to a == 7F for INC
  assign ovf = (a[7] == addend[7]) & (sum[7] != a[7]);

  // ------------------------------------------------
  // result and flags
  // ------------------------------------------------
  always_comb begin
    result = b;
    f_out  = f_in;

    case (op)
      OP_ADD, OP_ADC, OP_SUB: begin
        result         = sum;
        f_out[FLAG_S]  = sum[7];
        f_out[FLAG_Z]  = (sum == '0);
        f_out[FLAG_PV] = ovf;
        // a borrow is the missing carry of the inverted add
        f_out[FLAG_H]  = sum_lo[4] ^ is_sub;
        f_out[FLAG_C]  = sum_full[8] ^ is_sub;
        f_out[FLAG_N]  = is_sub;
      end

      OP_AND: begin
        result         = a & b;
        f_out[FLAG_S]  = result[7];
        f_out[FLAG_Z]  = (result == '0);
        // PV holds even parity here
        f_out[FLAG_PV] = ~^result;
        f_out[FLAG_H]  = 1'b1;
        f_out[FLAG_N]  = 1'b0;
        f_out[FLAG_C]  = 1'b0;
      end

      OP_INC: begin
        // carry is untouched by an increment
        result         = sum;
        f_out[FLAG_S]  = sum[7];
        f_out[FLAG_Z]  = (sum == '0);
        f_out[FLAG_PV] = ovf;
        f_out[FLAG_H]  = sum_lo[4];
        f_out[FLAG_N]  = 1'b0;
      end

      OP_CPL: begin
        result        = ~a;
        f_out[FLAG_H] = 1'b1;
        f_out[FLAG_N] = 1'b1;
      end

      OP_CCF: begin
        // old carry moves into H before it is flipped
        result        = a;
        f_out[FLAG_H] = f_in[FLAG_C];
        f_out[FLAG_C] = ~f_in[FLAG_C];
        f_out[FLAG_N] = 1'b0;
      end

      default: begin
        // PASS hands the B operand straight through
        result = b;
        f_out  = f_in;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- design/accum_flags.sv
`timescale 1ns/1ps
`default_nettype none

module accum_flags
  import z80_dp_pkg::*;
(
  input  logic     clk,
  input  logic     arst_n,
  input  dp_ctrl_t ctrl,
  input  byte_t    dbus,
  input  byte_t    alu_result,
  input  byte_t    alu_flags,
  output byte_t    a,
  output byte_t    f
);

  byte_t a_q;
  byte_t f_q;
  byte_t a_alt_q;
  byte_t f_alt_q;

  byte_t a_next;
  byte_t f_next;
  logic  f_wr;

  // an active override forces the bit to the low bit of its code
  function automatic logic apply_ovr(input logic cur, input flag_ovr_t ovr);
    return ovr[1] ? ovr[0] : cur;
  endfunction

  // ------------------------------------------------
  // write-back selection
  // ------------------------------------------------
  assign a_next = ctrl.a_from_alu ? alu_result : dbus;

  // start from the ALU flags or the current F and lay the overrides on top
  always_comb begin
    f_next = ctrl.ld_f ? alu_flags : f_q;

    f_next[FLAG_S]  = apply_ovr(f_next[FLAG_S],  ctrl.flag_ovr.s);
    f_next[FLAG_Z]  = apply_ovr(f_next[FLAG_Z],  ctrl.flag_ovr.z);
    f_next[FLAG_H]  = apply_ovr(f_next[FLAG_H],  ctrl.flag_ovr.h);
    f_next[FLAG_PV] = apply_ovr(f_next[FLAG_PV], ctrl.flag_ovr.pv);
    f_next[FLAG_N]  = apply_ovr(f_next[FLAG_N],  ctrl.flag_ovr.n);
    f_next[FLAG_C]  = apply_ovr(f_next[FLAG_C],  ctrl.flag_ovr.c);

    // an override on its own is enough to write F
    f_wr = ctrl.ld_f | ctrl.flag_ovr.s[1] | ctrl.flag_ovr.z[1] |
           ctrl.flag_ovr.h[1] | ctrl.flag_ovr.pv[1] |
           ctrl.flag_ovr.n[1] | ctrl.flag_ovr.c[1];
  end

  // ------------------------------------------------
  // registers
  // ------------------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      a_q     <= '0;
      f_q     <= '0;
      a_alt_q <= '0;
      f_alt_q <= '0;
    end else if (ctrl.ex_af) begin
      // EX AF,AF' blocks every other write to A and F in that cycle
      a_q     <= a_alt_q;
      f_q     <= f_alt_q;
      a_alt_q <= a_q;
      f_alt_q <= f_q;
    end else begin
      if (ctrl.ld_a) begin
        a_q <= a_next;
      end
      if (f_wr) begin
        f_q <= f_next;
      end
    end
  end

  assign a = a_q;
  assign f = f_q;

endmodule

`default_nettype wire

//--- design/bus_unit.sv
`timescale 1ns/1ps
`default_nettype none

module bus_unit
  import z80_dp_pkg::*;
(
  input  logic     clk,
  input  logic     arst_n,
  input  dp_ctrl_t ctrl,
  input  byte_t    data_in,
  input  byte_t    rd_byte,
  input  word_t    rd_pair,
  input  byte_t    a,
  input  byte_t    f,
  output byte_t    dbus,
  output word_t    abus,
  output byte_t    alu_b,
  output byte_t    data_out,
  output logic     data_oe,
  output word_t    addr_out,
  output logic     addr_oe
);

  byte_t temp_q;
  word_t mar_q;
  byte_t mar_hi_src;
  byte_t mar_lo_src;

  // ------------------------------------------------
  // bus arbitration
  // ------------------------------------------------
  // only the listed sources drive out and an unknown code falls back to data_in
  always_comb begin
    data_oe = 1'b1;
    case (ctrl.data_src)
      DS_REG:  dbus = rd_byte;
      DS_A:    dbus = a;
      DS_F:    dbus = f;
      DS_TEMP: dbus = temp_q;
      default: begin
        dbus    = data_in;
        data_oe = 1'b0;
      end
    endcase
  end

  always_comb begin
    addr_oe = 1'b1;
    case (ctrl.addr_src)
      AS_MAR:  abus = mar_q;
      AS_PAIR: abus = rd_pair;
      default: begin
        abus    = '0;
        addr_oe = 1'b0;
      end
    endcase
  end

  assign data_out = dbus;
  assign addr_out = abus;

  // TEMP lets a memory operand sit beside a register value on the data bus
  assign alu_b = ctrl.alu_b_temp ? temp_q : dbus;

  // ------------------------------------------------
  // TEMP and MAR
  // ------------------------------------------------
  // MAR is built byte by byte from the data bus or copied in halves from the address bus
  assign mar_hi_src = ctrl.mar_from_data ? dbus : abus[WORD_W-1:BYTE_W];
  assign mar_lo_src = ctrl.mar_from_data ? dbus : abus[BYTE_W-1:0];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      temp_q <= '0;
      mar_q  <= '0;
    end else begin
      if (ctrl.ld_temp) begin
        temp_q <= dbus;
      end
      if (ctrl.ld_mar_hi) begin
        mar_q[WORD_W-1:BYTE_W] <= mar_hi_src;
      end
      if (ctrl.ld_mar_lo) begin
        mar_q[BYTE_W-1:0] <= mar_lo_src;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/z80_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module z80_datapath
  import z80_dp_pkg::*;
(
  input  logic     clk,
  input  logic     arst_n,
  input  dp_ctrl_t ctrl,
  input  byte_t    data_in,
  output byte_t    data_out,
  output logic     data_oe,
  output word_t    addr_out,
  output logic     addr_oe,
  output byte_t    flags
);

  // ------------------------------------------------
  // internal buses and unit outputs
  // ------------------------------------------------
  byte_t dbus;
  word_t abus;
  byte_t rd_byte;
  word_t rd_pair;
  byte_t acc;
  byte_t flag_reg;
  byte_t alu_b;
  byte_t alu_result;
  byte_t alu_flags;

  // general registers read onto and load from both buses
  reg_file i_reg_file (
    .clk     (clk),
    .arst_n  (arst_n),
    .ctrl    (ctrl),
    .dbus    (dbus),
    .abus    (abus),
    .rd_byte (rd_byte),
    .rd_pair (rd_pair)
  );

  // the ALU always works on A and the current F
  alu8 i_alu8 (
    .op     (ctrl.alu_op),
    .a      (acc),
    .b      (alu_b),
    .f_in   (flag_reg),
    .result (alu_result),
    .f_out  (alu_flags)
  );

  accum_flags i_accum_flags (
    .clk        (clk),
    .arst_n     (arst_n),
    .ctrl       (ctrl),
    .dbus       (dbus),
    .alu_result (alu_result),
    .alu_flags  (alu_flags),
    .a          (acc),
    .f          (flag_reg)
  );

  // sole driver of both buses and of the output-enables
  bus_unit i_bus_unit (
    .clk      (clk),
    .arst_n   (arst_n),
    .ctrl     (ctrl),
    .data_in  (data_in),
    .rd_byte  (rd_byte),
    .rd_pair  (rd_pair),
    .a        (acc),
    .f        (flag_reg),
    .dbus     (dbus),
    .abus     (abus),
    .alu_b    (alu_b),
    .data_out (data_out),
    .data_oe  (data_oe),
    .addr_out (addr_out),
    .addr_oe  (addr_oe)
  );

  // the sequencer sees F directly
  assign flags = flag_reg;

endmodule

`default_nettype wire

//--- dv/z80_datapath_assert.sv
`timescale 1ns/1ps
`default_nettype none

module z80_datapath_assert
  import z80_dp_pkg::*;
(
  input logic     clk,
  input logic     arst_n,
  input dp_ctrl_t ctrl,
  input logic     data_oe,
  input logic     addr_oe,
  input byte_t    flags
);

  logic f_write;

  // only the set and clear codes force a flag
  function automatic logic ovr_on(input flag_ovr_t o);
    return (o == FO_SET) || (o == FO_CLR);
  endfunction

  // any of these may move F at the coming edge
  assign f_write = ctrl.ld_f || ctrl.ex_af ||
                   ovr_on(ctrl.flag_ovr.s) || ovr_on(ctrl.flag_ovr.z) ||
                   ovr_on(ctrl.flag_ovr.h) || ovr_on(ctrl.flag_ovr.pv) ||
                   ovr_on(ctrl.flag_ovr.n) || ovr_on(ctrl.flag_ovr.c);

  // ------------------------------------------------
  // output-enables and flag stability
  // ------------------------------------------------
  data_oe_idle: assert property (@(posedge clk) disable iff (!arst_n)
    (ctrl.data_src == DS_EXT) |-> !data_oe)
    else $error("data_oe is high while the data bus takes data_in");

  addr_oe_idle: assert property (@(posedge clk) disable iff (!arst_n)
    (ctrl.addr_src == AS_NONE) |-> !addr_oe)
    else $error("addr_oe is high with no address source selected");

  // F may only change one edge after a cycle that writes it
  flags_hold: assert property (@(posedge clk) disable iff (!arst_n)
    !f_write |=> $stable(flags))
    else $error("flags changed without ld_f, an override or EX AF");

endmodule

`default_nettype wire

//--- dv/tb_z80_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module tb_z80_datapath
  import z80_dp_pkg::*;
();

  // ------------------------------------------------
  // DUT signals and reference state
  // ------------------------------------------------
  // the tests take about 400 cycles, so this leaves plenty of margin
  localparam int MAX_CYCLES = 2000;

  logic     clk;
  logic     arst_n;
  dp_ctrl_t ctrl;
  byte_t    data_in;
  byte_t    data_out;
  logic     data_oe;
  word_t    addr_out;
  logic     addr_oe;
  byte_t    flags;

  // expected contents of every register, kept in step with each control word
  byte_t rm [NUM_REG8];
  byte_t sh [NUM_SHADOW];
  byte_t a_m;
  byte_t f_m;
  byte_t a_sh;
  byte_t f_sh;
  int    cycle_cnt = 0;

  string reg_names [NUM_REG8] = '{"B", "C", "D", "E", "H", "L", "SPH", "SPL", "PCH", "PCL"};
  string pair_names [5] = '{"BC", "DE", "HL", "SP", "PC"};
  int    flag_pos [6] = '{FLAG_S, FLAG_Z, FLAG_H, FLAG_PV, FLAG_N, FLAG_C};

  z80_datapath i_z80_datapath (
    .clk      (clk),
    .arst_n   (arst_n),
    .ctrl     (ctrl),
    .data_in  (data_in),
    .data_out (data_out),
    .data_oe  (data_oe),
    .addr_out (addr_out),
    .addr_oe  (addr_oe),
    .flags    (flags)
  );

  bind z80_datapath z80_datapath_assert i_z80_datapath_assert (
    .clk     (clk),
    .arst_n  (arst_n),
    .ctrl    (ctrl),
    .data_oe (data_oe),
    .addr_oe (addr_oe),
    .flags   (flags)
  );

  always #50 clk = ~clk;

  // the run is cut off if the tests stall somewhere
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Simulation failed");
      $fatal(1, "timeout, the tests did not finish within %0d cycles", MAX_CYCLES);
    end
  end

  // ------------------------------------------------
  // helpers
  // ------------------------------------------------
  task automatic check(input string name, input logic [15:0] actual,
                       input logic [15:0] expected);
    if (actual !== expected) begin
      $display("FAIL time=%0t %s actual=%h expected=%h", $time, name, actual, expected);
      $display("Simulation failed");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  // a new control word goes on at the falling edge and takes effect at the rising one
  // the combinational outputs have settled 10 ns later
  task automatic drive(input dp_ctrl_t c, input byte_t d);
    @(negedge clk);
    ctrl    = c;
    data_in = d;
    #10;
  endtask

  function automatic flag_ovr_t one_ovr(input logic en, input logic v);
    if (!en) begin
      return FO_KEEP;
    end
    return v ? FO_SET : FO_CLR;
  endfunction

  // every flag whose mask bit is set gets forced to the matching bit of val
  function automatic flag_ctrl_t ovr_from(input byte_t val, input byte_t mask);
    flag_ctrl_t o;
    o.s  = one_ovr(mask[FLAG_S], val[FLAG_S]);
    o.z  = one_ovr(mask[FLAG_Z], val[FLAG_Z]);
    o.h  = one_ovr(mask[FLAG_H], val[FLAG_H]);
    o.pv = one_ovr(mask[FLAG_PV], val[FLAG_PV]);
    o.n  = one_ovr(mask[FLAG_N], val[FLAG_N]);
    o.c  = one_ovr(mask[FLAG_C], val[FLAG_C]);
    return o;
  endfunction

  function automatic int sval(input byte_t v);
    return v[7] ? int'(v) - 256 : int'(v);
  endfunction

  // reference ALU worked out in integer arithmetic, returns {result, flags}
  function automatic logic [15:0] alu_ref(input alu_op_t op, input byte_t a,
                                          input byte_t b, input byte_t f);
    int    ia;
    int    ib;
    int    sum;
    int    sv;
    int    cin;
    byte_t r;
    byte_t fo;
    ia = int'(a);
    ib = int'(b);
    fo = f;
    r  = b;
    case (op)
      OP_ADD, OP_ADC: begin
        cin = (op == OP_ADC && f[FLAG_C]) ? 1 : 0;
        sum = ia + ib + cin;
        r   = 8'(sum);
        sv  = sval(a) + sval(b) + cin;
        fo[FLAG_H]  = ((ia % 16) + (ib % 16) + cin) > 15;
        fo[FLAG_C]  = sum > 255;
        fo[FLAG_PV] = (sv > 127) || (sv < -128);
        fo[FLAG_N]  = 1'b0;
      end
      OP_SUB: begin
        r  = 8'(ia - ib);
        sv = sval(a) - sval(b);
        fo[FLAG_H]  = (ia % 16) < (ib % 16);
        fo[FLAG_C]  = ia < ib;
        fo[FLAG_PV] = (sv > 127) || (sv < -128);
        fo[FLAG_N]  = 1'b1;
      end
      OP_AND: begin
        r = a & b;
        fo[FLAG_PV] = ($countones(r) % 2) == 0;
        fo[FLAG_H]  = 1'b1;
        fo[FLAG_N]  = 1'b0;
        fo[FLAG_C]  = 1'b0;
      end
      OP_INC: begin
        r = 8'(ia + 1);
        fo[FLAG_H]  = (ia % 16) == 15;
        fo[FLAG_PV] = (a == 8'h7f);
        fo[FLAG_N]  = 1'b0;
      end
      OP_CPL: begin
        r = ~a;
        fo[FLAG_H] = 1'b1;
        fo[FLAG_N] = 1'b1;
      end
      OP_CCF: begin
        r = a;
        fo[FLAG_H] = f[FLAG_C];
        fo[FLAG_C] = ~f[FLAG_C];
        fo[FLAG_N] = 1'b0;
      end
      default: r = b;
    endcase
    // sign and zero follow the result for the arithmetic and logic group
    if (op == OP_ADD || op == OP_ADC || op == OP_SUB || op == OP_AND || op == OP_INC) begin
      fo[FLAG_S] = r[7];
      fo[FLAG_Z] = (r == 8'h00);
    end
    return {r, fo};
  endfunction

  task automatic swap_shadow_set();
    byte_t t;
    for (int i = 0; i < NUM_SHADOW; i++) begin
      t     = rm[i];
      rm[i] = sh[i];
      sh[i] = t;
    end
  endtask

  task automatic swap_de_hl();
    byte_t t;
    t        = rm[R_D];
    rm[R_D]  = rm[R_H];
    rm[R_H]  = t;
    t        = rm[R_E];
    rm[R_E]  = rm[R_L];
    rm[R_L]  = t;
  endtask

  task automatic swap_af();
    byte_t t;
    t    = a_m;
    a_m  = a_sh;
    a_sh = t;
    t    = f_m;
    f_m  = f_sh;
    f_sh = t;
  endtask

  task automatic load_byte(input int r, input byte_t v);
    dp_ctrl_t c;
    c = '0;
    c.rf_ld_en  = 1'b1;
    c.rf_ld_sel = reg8_sel_t'(r);
    drive(c, v);
    rm[r] = v;
  endtask

  // loads A from data_in and writes F through overrides alone
  // bits 5 and 3 have no flag behind them and keep their old value
  task automatic load_af(input byte_t av, input byte_t fv);
    dp_ctrl_t c;
    c = '0;
    c.ld_a     = 1'b1;
    c.flag_ovr = ovr_from(fv, 8'hD7);
    drive(c, av);
    a_m = av;
    f_m = (f_m & 8'h28) | (fv & 8'hD7);
  endtask

  task automatic read_byte_reg(input int r);
    dp_ctrl_t c;
    c = '0;
    c.data_src  = DS_REG;
    c.rf_rd_sel = reg8_sel_t'(r);
    drive(c, 8'h5a);
    check({"data_out ", reg_names[r]}, 16'(data_out), 16'(rm[r]));
    check("data_oe", 16'(data_oe), 16'd1);
  endtask

  // reads every byte register, A and F back through the data bus
  task automatic verify_state();
    dp_ctrl_t c;
    for (int r = 0; r < NUM_REG8; r++) begin
      read_byte_reg(r);
    end
    c = '0;
    c.data_src = DS_A;
    drive(c, 8'h00);
    check("data_out A", 16'(data_out), 16'(a_m));
    c.data_src = DS_F;
    drive(c, 8'h00);
    check("data_out F", 16'(data_out), 16'(f_m));
    check("flags", 16'(flags), 16'(f_m));
  endtask

  // ------------------------------------------------
  // tests
  // ------------------------------------------------
  task automatic reset_values();
    dp_ctrl_t c;
    c = '0;
    drive(c, 8'ha5);
    check("data_oe", 16'(data_oe), 16'd0);
    check("addr_oe", 16'(addr_oe), 16'd0);
    check("data_out", 16'(data_out), 16'h00a5);
    check("flags", 16'(flags), 16'd0);
    verify_state();
    c = '0;
    c.data_src = DS_TEMP;
    drive(c, 8'hc3);
    check("data_out TEMP", 16'(data_out), 16'd0);
    check("data_oe", 16'(data_oe), 16'd1);
    c = '0;
    c.addr_src = AS_MAR;
    drive(c, 8'h00);
    check("addr_out MAR", addr_out, 16'd0);
    check("addr_oe", 16'(addr_oe), 16'd1);
  endtask

  task automatic byte_and_pair_loads();
    dp_ctrl_t c;
    word_t    w;
    for (int r = 0; r < NUM_REG8; r++) begin
      load_byte(r, 8'($urandom));
    end
    load_af(8'($urandom), f_m);
    verify_state();
    // SP and PC take a MAR value that was assembled one byte at a time
    for (int p = P_SP; p <= P_PC; p++) begin
      w = 16'($urandom);
      c = '0;
      c.mar_from_data = 1'b1;
      c.ld_mar_hi     = 1'b1;
      drive(c, w[15:8]);
      c.ld_mar_hi = 1'b0;
      c.ld_mar_lo = 1'b1;
      drive(c, w[7:0]);
      c = '0;
      c.addr_src    = AS_MAR;
      c.rf_pair_ld  = 1'b1;
      c.rf_pair_sel = pair_sel_t'(p);
      drive(c, 8'h00);
      check("addr_out MAR", addr_out, w);
      check("addr_oe", 16'(addr_oe), 16'd1);
      rm[2 * p]     = w[15:8];
      rm[2 * p + 1] = w[7:0];
    end
    for (int p = 0; p < 5; p++) begin
      c = '0;
      c.addr_src    = AS_PAIR;
      c.rf_pair_sel = pair_sel_t'(p);
      drive(c, 8'h00);
      check({"addr_out ", pair_names[p]}, addr_out, {rm[2 * p], rm[2 * p + 1]});
    end
    // TEMP takes a byte from data_in and gives it back on the data bus
    w = 16'($urandom);
    c = '0;
    c.ld_temp = 1'b1;
    drive(c, w[7:0]);
    c = '0;
    c.data_src = DS_TEMP;
    drive(c, ~w[7:0]);
    check("data_out TEMP", 16'(data_out), 16'(w[7:0]));
    check("data_oe", 16'(data_oe), 16'd1);
    // MAR can also copy a whole pair from the address bus
    c = '0;
    c.addr_src    = AS_PAIR;
    c.rf_pair_sel = P_HL;
    c.ld_mar_hi   = 1'b1;
    c.ld_mar_lo   = 1'b1;
    drive(c, 8'h00);
    c = '0;
    c.addr_src = AS_MAR;
    drive(c, 8'h00);
    check("addr_out MAR", addr_out, {rm[R_H], rm[R_L]});
  endtask

  task automatic register_exchanges();
    dp_ctrl_t c;
    // fill the shadow set by swapping it in and loading fresh values
    c = '0;
    c.exx = 1'b1;
    drive(c, 8'h00);
    swap_shadow_set();
    for (int r = 0; r < NUM_SHADOW; r++) begin
      load_byte(r, 8'($urandom));
    end
    verify_state();
    // two EX DE,HL in a row must give the starting values back
    for (int n = 0; n < 2; n++) begin
      c = '0;
      c.ex_de_hl = 1'b1;
      drive(c, 8'h00);
      swap_de_hl();
      verify_state();
    end
    for (int n = 0; n < 2; n++) begin
      c = '0;
      c.exx = 1'b1;
      drive(c, 8'h00);
      swap_shadow_set();
      verify_state();
    end
    // same idea for the accumulator and flags pair
    load_af(8'($urandom), 8'($urandom));
    c = '0;
    c.ex_af = 1'b1;
    drive(c, 8'h00);
    swap_af();
    load_af(8'($urandom), 8'($urandom));
    verify_state();
    for (int n = 0; n < 2; n++) begin
      c = '0;
      c.ex_af = 1'b1;
      drive(c, 8'h00);
      swap_af();
      verify_state();
    end
  endtask

  task automatic alu_operations();
    alu_op_t     ops [8] = '{OP_PASS, OP_ADD, OP_ADC, OP_SUB, OP_AND, OP_INC, OP_CPL, OP_CCF};
    dp_ctrl_t    c;
    byte_t       bv;
    logic        use_temp;
    logic [15:0] exp;
    for (int rep = 0; rep < 6; rep++) begin
      for (int k = 0; k < 8; k++) begin
        bv       = 8'($urandom);
        use_temp = 1'($urandom);
        load_af(8'($urandom), 8'($urandom));
        if (use_temp) begin
          c = '0;
          c.ld_temp = 1'b1;
          drive(c, bv);
        end
        // with TEMP as operand the bus carries a different byte that must be ignored
        c = '0;
        c.alu_op     = ops[k];
        c.ld_a       = 1'b1;
        c.a_from_alu = 1'b1;
        c.ld_f       = 1'b1;
        c.alu_b_temp = use_temp;
        drive(c, use_temp ? ~bv : bv);
        exp = alu_ref(ops[k], a_m, bv, f_m);
        a_m = exp[15:8];
        f_m = exp[7:0];
        c = '0;
        c.data_src = DS_A;
        drive(c, 8'h00);
        check("data_out A", 16'(data_out), 16'(a_m));
        check("flags", 16'(flags), 16'(f_m));
      end
    end
  endtask

  task automatic flag_overrides();
    dp_ctrl_t    c;
    byte_t       bv;
    byte_t       mask;
    byte_t       other;
    logic [15:0] exp;
    for (int k = 0; k < 6; k++) begin
      for (int s = 0; s < 2; s++) begin
        load_af(8'($urandom), 8'($urandom));
        // one flag forced on top of an ADD that writes only F
        bv   = 8'($urandom);
        mask = 8'(1 << flag_pos[k]);
        c = '0;
        c.alu_op   = OP_ADD;
        c.ld_f     = 1'b1;
        c.flag_ovr = ovr_from({8{s[0]}}, mask);
        drive(c, bv);
        exp = alu_ref(OP_ADD, a_m, bv, f_m);
        f_m = (exp[7:0] & ~mask) | ({8{s[0]}} & mask);
        // next flag flipped by an override with no ld_f
        other = 8'(1 << flag_pos[(k + 1) % 6]);
        c = '0;
        c.flag_ovr = ovr_from(~f_m, other);
        drive(c, 8'h00);
        check("flags", 16'(flags), 16'(f_m));
        f_m = f_m ^ other;
        c = '0;
        c.data_src = DS_A;
        drive(c, 8'h00);
        check("flags", 16'(flags), 16'(f_m));
        check("data_out A", 16'(data_out), 16'(a_m));
      end
    end
  endtask

  // ------------------------------------------------
  // main sequence
  // ------------------------------------------------
  initial begin
    void'($urandom(97876));
    clk     = 1'b0;
    arst_n  = 1'b0;
    ctrl    = '0;
    data_in = '0;
    for (int i = 0; i < NUM_REG8; i++) begin
      rm[i] = '0;
    end
    for (int i = 0; i < NUM_SHADOW; i++) begin
      sh[i] = '0;
    end
    a_m  = '0;
    f_m  = '0;
    a_sh = '0;
    f_sh = '0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    reset_values();
    byte_and_pair_loads();
    register_exchanges();
    alu_operations();
    flag_overrides();

    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
design/z80_dp_pkg.sv
design/reg_file.sv
design/alu8.sv
design/accum_flags.sv
design/bus_unit.sv
design/z80_datapath.sv
dv/z80_datapath_assert.sv
dv/tb_z80_datapath.sv

//--- run_sim.sh
#!/bin/sh
# build the datapath testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_z80_datapath -Mdir obj_dir -f sim.f

# a $fatal anywhere in the run gives a non-zero exit status
./obj_dir/Vtb_z80_datapath
